// File: tb.f
src/rvfi_chk_pkg.sv
src/rvfi_trace_if.sv
src/rvfi_trace_decode.sv
src/rvfi_rule_check.sv
src/rvfi_violation_log.sv
src/rvfi_checker_top.sv
testbench/tb_rvfi_checker.sv

// File: testbench/rvfi_checker_tests.txt
# valid trap intr dbg mcause dcsr pc nmi_addr debug_mode pending_nmi dbg_ack exp_viol
# One cycle per line, hex fields, exp_viol is the viol_o vector one cycle later
1 0001 0 0 00000000 00000000 00000000 00001003 0 0 0 00
1 0000 0 0 00000000 00000000 00000000 00001003 0 0 0 01
1 0001 0 0 00000000 00000000 00000000 00001003 0 0 0 00
0 0000 0 0 00000000 00000000 00000000 00001003 1 0 0 00
1 0000 0 0 00000000 00000000 00000000 00001003 0 0 0 00
1 002b 0 0 00000000 00000000 00000000 00001003 0 0 0 00
1 0000 1 0 00000007 00000000 00000000 00001003 0 0 0 04
1 002b 0 0 00000000 00000000 00000000 00001003 0 0 0 00
0 0000 0 0 00000000 00000000 00000000 00001003 0 1 0 00
1 0000 1 0 00000007 00000000 00000000 00001003 0 0 0 00
1 0605 0 0 00000000 00000000 00000000 00001003 0 0 0 00
1 0000 1 0 00000000 00000000 00000000 00001003 0 0 0 0a
0 0000 0 0 00000000 00000000 00000000 00001003 0 0 1 00
1 0605 0 0 00000000 00000000 00000000 00001003 0 0 0 00
1 0000 1 2 00000000 00000000 00000000 00001003 0 0 0 08
0 0000 0 0 00000000 00000000 00000000 00001003 0 0 1 00
1 0407 0 0 00000000 00000000 00000000 00001003 0 0 0 10
1 0000 1 2 00000000 00000100 00000000 00001003 0 0 0 00
1 0000 0 1 00000000 00000000 00000000 00001003 0 0 0 20
0 0000 0 0 00000000 00000000 00000000 00001003 0 0 1 00
1 0000 0 1 00000000 00000000 00000000 00001003 0 0 0 00
1 0000 0 0 00000000 00000008 00000000 00001003 0 0 0 00
1 0000 1 0 00000080 00000000 00002000 00001003 0 0 0 40
1 0000 0 0 00000000 00000008 00000000 00001003 0 0 0 00
1 0000 1 0 00000081 00000000 00001000 00001003 0 0 0 00

// File: testbench/tb_rvfi_checker.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the retirement trace checker that replays the test vector
// file and checks the violation pulses, the error flag and the final counts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_rvfi_checker;

  localparam int RESET_TIMEOUT = 50;
  localparam int MAX_LINES     = 200;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     rvfi_valid;
  rvfi_chk_pkg::trap_t      rvfi_trap;
  logic                     rvfi_intr;
  rvfi_chk_pkg::dbg_cause_t rvfi_dbg;
  rvfi_chk_pkg::word_t      rvfi_mcause;
  rvfi_chk_pkg::word_t      rvfi_dcsr;
  rvfi_chk_pkg::word_t      rvfi_pc;
  rvfi_chk_pkg::word_t      nmi_addr;
  logic                     debug_mode;
  logic                     pending_nmi;
  logic                     dbg_ack;
  rvfi_chk_pkg::rule_vec_t  viol;
  logic                     error_flag;

  rvfi_chk_pkg::viol_cnt_t [rvfi_chk_pkg::NUM_RULES-1:0] viol_cnt;

  // Running totals of checks and failures and the model of the log
  int   errors    = 0;
  int   checks    = 0;
  logic exp_error = 1'b0;
  int   exp_cnt [rvfi_chk_pkg::NUM_RULES];

  rvfi_checker_top DUT (
    .clk_i (clk_i), .rst_ni (rst_ni), .rvfi_valid_i (rvfi_valid),
    .rvfi_trap_i (rvfi_trap), .rvfi_intr_i (rvfi_intr), .rvfi_dbg_i (rvfi_dbg),
    .rvfi_mcause_i (rvfi_mcause), .rvfi_dcsr_i (rvfi_dcsr), .rvfi_pc_i (rvfi_pc),
    .nmi_addr_i (nmi_addr), .debug_mode_i (debug_mode), .pending_nmi_i (pending_nmi),
    .dbg_ack_i (dbg_ack), .viol_o (viol), .error_o (error_flag), .viol_cnt_o (viol_cnt)
  );

  // 100 ns clock period
  always #50 clk_i = ~clk_i;

  // Reset held low for the first 10 rising edges
  initial begin
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_inputs(input logic [31:0] f [11]);
    rvfi_valid  <= f[0][0];
    rvfi_trap   <= f[1][13:0];
    rvfi_intr   <= f[2][0];
    rvfi_dbg    <= f[3][2:0];
    rvfi_mcause <= f[4];
    rvfi_dcsr   <= f[5];
    rvfi_pc     <= f[6];
    nmi_addr    <= f[7];
    debug_mode  <= f[8][0];
    pending_nmi <= f[9][0];
    dbg_ack     <= f[10][0];
  endtask

  // The expected vector also feeds the sticky flag and the per-rule sums
  task automatic check_outputs(input rvfi_chk_pkg::rule_vec_t exp_viol);
    exp_error = exp_error || (exp_viol != '0);
    for (int r = 0; r < rvfi_chk_pkg::NUM_RULES; r++) begin
      exp_cnt[r] += exp_viol[r];
    end
    checks += 2;
    assert (viol === exp_viol) else begin
      errors++;
      $display("Fail at %0t: viol_o is %h, expected %h", $time, viol, exp_viol);
    end
    assert (error_flag === exp_error) else begin
      errors++;
      $display("Fail at %0t: error_o is %b, expected %b", $time, error_flag, exp_error);
    end
  endtask

  task automatic check_counts();
    for (int r = 0; r < rvfi_chk_pkg::NUM_RULES; r++) begin
      checks++;
      assert (viol_cnt[r] === 8'(exp_cnt[r])) else begin
        errors++;
        $display("Fail at %0t: viol_cnt_o[%0d] is %0d, expected %0d",
                 $time, r, viol_cnt[r], exp_cnt[r]);
      end
    end
  endtask

  // Inputs of a line go in on one edge and its result is checked one cycle later
  task automatic replay_tests(output bit ok);
    int                      fd;
    int                      n;
    int                      lines;
    string                   line;
    logic [31:0]             f [11];
    logic [31:0]             exp_raw;
    rvfi_chk_pkg::rule_vec_t prev_exp;
    ok       = 1'b1;
    lines    = 0;
    prev_exp = '0;
    fd = $fopen("testbench/rvfi_checker_tests.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open the test vector file");
      ok = 1'b0;
    end else begin
      while (!$feof(fd) && lines < MAX_LINES) begin
        lines++;
        n = $fgets(line, fd);
        // Comment lines start with a hash and blank lines scan nothing
        if (n > 0 && !(line.len() > 0 && line.substr(0, 0) == "#")) begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                      f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], exp_raw);
          if (n == 12) begin
            @(posedge clk_i);
            apply_inputs(f);
            @(negedge clk_i);
            check_outputs(prev_exp);
            prev_exp = exp_raw[rvfi_chk_pkg::NUM_RULES-1:0];
          end else if (n > 0) begin
            $display("Error: malformed line %0d in the test vector file", lines);
            ok = 1'b0;
          end
        end
      end
      if (!$feof(fd)) begin
        $display("Error: test vector file longer than %0d lines", MAX_LINES);
        ok = 1'b0;
      end
      $fclose(fd);
      // One idle cycle brings out the result of the last line
      f = '{default: '0};
      @(posedge clk_i);
      apply_inputs(f);
      @(negedge clk_i);
      check_outputs(prev_exp);
    end
  endtask

  initial begin
    logic [31:0] idle [11];
    int          cycles;
    bit          ok;
    idle = '{default: '0};
    apply_inputs(idle);
    foreach (exp_cnt[r]) exp_cnt[r] = 0;
    cycles = 0;
    while (rst_ni !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (rst_ni !== 1'b1) begin
      $display("Error: timeout waiting for reset release");
      errors++;
    end else begin
      replay_tests(ok);
      if (!ok) begin
        errors++;
      end
      check_counts();
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: src/rvfi_checker_top.sv
////////////////////////////////////////////////////////////////////////////
// Retirement trace checker top level connecting decode, rule check and log
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rvfi_checker_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      rvfi_valid_i,
  input  rvfi_chk_pkg::trap_t       rvfi_trap_i,
  input  logic                      rvfi_intr_i,
  input  rvfi_chk_pkg::dbg_cause_t  rvfi_dbg_i,
  input  rvfi_chk_pkg::word_t       rvfi_mcause_i,
  input  rvfi_chk_pkg::word_t       rvfi_dcsr_i,
  input  rvfi_chk_pkg::word_t       rvfi_pc_i,
  input  rvfi_chk_pkg::word_t       nmi_addr_i,
  input  logic                      debug_mode_i,
  input  logic                      pending_nmi_i,
  input  logic                      dbg_ack_i,
  output rvfi_chk_pkg::rule_vec_t   viol_o,
  output logic                      error_o,
  output rvfi_chk_pkg::viol_cnt_t [rvfi_chk_pkg::NUM_RULES-1:0] viol_cnt_o
);

  rvfi_chk_pkg::rule_vec_t viol_now;
  logic                    viol_strobe;

  // Decoded retirement and armed state between decode and check
  rvfi_trace_if trace_if ();

  rvfi_trace_decode u_decode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rvfi_valid_i  (rvfi_valid_i),
    .rvfi_trap_i   (rvfi_trap_i),
    .rvfi_intr_i   (rvfi_intr_i),
    .rvfi_dbg_i    (rvfi_dbg_i),
    .rvfi_mcause_i (rvfi_mcause_i),
    .rvfi_dcsr_i   (rvfi_dcsr_i),
    .rvfi_pc_i     (rvfi_pc_i),
    .nmi_addr_i    (nmi_addr_i),
    .debug_mode_i  (debug_mode_i),
    .pending_nmi_i (pending_nmi_i),
    .dbg_ack_i     (dbg_ack_i),
    .trace_o       (trace_if.decode_mp)
  );

  rvfi_rule_check u_check (
    .trace_i       (trace_if.check_mp),
    .viol_now_o    (viol_now),
    .viol_strobe_o (viol_strobe)
  );

  rvfi_violation_log u_log (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .viol_now_i    (viol_now),
    .viol_strobe_i (viol_strobe),
    .viol_o        (viol_o),
    .error_o       (error_o),
    .viol_cnt_o    (viol_cnt_o)
  );

endmodule

// File: src/rvfi_violation_log.sv
////////////////////////////////////////////////////////////////////////////
// Violation log with registered violation pulses, per-rule saturating
// counts and the sticky error flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rvfi_violation_log (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rvfi_chk_pkg::rule_vec_t   viol_now_i,
  input  logic                      viol_strobe_i,
  output rvfi_chk_pkg::rule_vec_t   viol_o,
  output logic                      error_o,
  output rvfi_chk_pkg::viol_cnt_t [rvfi_chk_pkg::NUM_RULES-1:0] viol_cnt_o
);

  rvfi_chk_pkg::rule_vec_t viol_q;
  logic                    error_q;

  rvfi_chk_pkg::viol_cnt_t [rvfi_chk_pkg::NUM_RULES-1:0] cnt_q;

  // Violation pulses appear one cycle after the offending retirement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_q <= '0;
    end else begin
      viol_q <= viol_now_i;
    end
  end

  // Error flag stays set until the next reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      error_q <= 1'b0;
    end else if (viol_strobe_i) begin
      error_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-rule counts
  ////////////////////////////////////////////////////////////////////////////

  // Each count holds at 255 once it gets there
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int r = 0; r < rvfi_chk_pkg::NUM_RULES; r++) begin
        if (viol_now_i[r] && (cnt_q[r] != '1)) begin
          cnt_q[r] <= cnt_q[r] + 8'd1;
        end
      end
    end
  end

  assign viol_o     = viol_q;
  assign error_o    = error_q;
  assign viol_cnt_o = cnt_q;

endmodule

// File: src/rvfi_rule_check.sv
////////////////////////////////////////////////////////////////////////////
// Combinational rule evaluation on each valid retirement that produces
// the violation vector and a strobe when any rule fails
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rvfi_rule_check (
  rvfi_trace_if.check_mp            trace_i,
  output rvfi_chk_pkg::rule_vec_t   viol_now_o,
  output logic                      viol_strobe_o
);

  logic cur_exc;
  logic cur_dbg;
  logic mcause_match;
  logic nmi_cause_ok;
  logic nmi_entry_ok;

  rvfi_chk_pkg::dbg_cause_t  cur_dbg_cause;
  rvfi_chk_pkg::rule_vec_t   viol;

  ////////////////////////////////////////////////////////////////////////////
  // Helper terms
  ////////////////////////////////////////////////////////////////////////////

  assign cur_exc       = trace_i.ret_trap[rvfi_chk_pkg::EXC_BIT];
  assign cur_dbg       = trace_i.ret_trap[rvfi_chk_pkg::DBG_BIT];
  assign cur_dbg_cause = trace_i.ret_trap[rvfi_chk_pkg::DBG_CAUSE_LSB +: 3];

  // Low mcause bits must repeat the exception cause of the trap
  assign mcause_match = (trace_i.ret_mcause_cause[5:0] == trace_i.prev_exc_cause);

  // An NMI reports either a load or a store bus fault
  assign nmi_cause_ok =
    (trace_i.ret_mcause_cause == rvfi_chk_pkg::INT_CAUSE_LOAD_FAULT) ||
    (trace_i.ret_mcause_cause == rvfi_chk_pkg::INT_CAUSE_STORE_FAULT);

  assign nmi_entry_ok = trace_i.ret_intr && (trace_i.ret_pc == trace_i.nmi_pc) &&
                        nmi_cause_ok;

  ////////////////////////////////////////////////////////////////////////////
  // Rule evaluation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    viol = '0;

    // Any trap is followed by a retirement flagged as interrupt entry
    viol[rvfi_chk_pkg::R_TRAP_INTR] = trace_i.armed_trap_intr && !trace_i.ret_intr;

    // A debug trap is followed by debug entry
    viol[rvfi_chk_pkg::R_TRAP_DBG] = trace_i.armed_trap_dbg && (trace_i.ret_dbg == '0);

    viol[rvfi_chk_pkg::R_MCAUSE_ALIGN] =
      trace_i.armed_mcause && !(trace_i.ret_intr && mcause_match);

    // Debug entry repeats the cause of the debug trap. After an exception
    // under single step, dcsr.cause must also report stepping
    viol[rvfi_chk_pkg::R_DBG_CAUSE_ALIGN] =
      (trace_i.armed_trap_dbg && (trace_i.ret_dbg != trace_i.prev_dbg_cause)) ||
      (trace_i.armed_step_ok && (trace_i.ret_dcsr_cause != rvfi_chk_pkg::DBG_CAUSE_STEP));

    // Checked within the retirement itself without any armed state
    viol[rvfi_chk_pkg::R_STEP_TRAP] =
      cur_exc && cur_dbg && (cur_dbg_cause != rvfi_chk_pkg::DBG_CAUSE_STEP);

    // Debug entry without an acknowledge from the core
    viol[rvfi_chk_pkg::R_DBG_ACK] = (trace_i.ret_dbg != '0) && !trace_i.dbg_ack_pending;

    viol[rvfi_chk_pkg::R_NMI_HANDLER] = trace_i.armed_nmi && !nmi_entry_ok;

    // Only a valid retirement is judged
    if (!trace_i.ret_valid) begin
      viol = '0;
    end
  end

  assign viol_now_o    = viol;
  assign viol_strobe_o = |viol;

endmodule

// File: src/rvfi_trace_decode.sv
////////////////////////////////////////////////////////////////////////////
// Retirement trace decoder that unpacks the trap word, keeps the previous
// trap word, arms the follow-up rules, tracks their qualifiers and
// counts outstanding debug acknowledges
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rvfi_trace_decode (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       rvfi_valid_i,
  input  rvfi_chk_pkg::trap_t        rvfi_trap_i,
  input  logic                       rvfi_intr_i,
  input  rvfi_chk_pkg::dbg_cause_t   rvfi_dbg_i,
  input  rvfi_chk_pkg::word_t        rvfi_mcause_i,
  input  rvfi_chk_pkg::word_t        rvfi_dcsr_i,
  input  rvfi_chk_pkg::word_t        rvfi_pc_i,
  input  rvfi_chk_pkg::word_t        nmi_addr_i,
  input  logic                       debug_mode_i,
  input  logic                       pending_nmi_i,
  input  logic                       dbg_ack_i,
  rvfi_trace_if.decode_mp            trace_o
);

  rvfi_chk_pkg::trap_t trap_q;
  rvfi_chk_pkg::word_t nmi_addr_q;

  logic trap_intr_q;
  logic trap_dbg_q;
  logic mcause_q;
  logic step_q;
  logic nmi_q;

  logic       no_debug;
  logic       mcause_qual;
  logic       nmi_qual;
  logic       dbg_ret;
  logic [1:0] ack_cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Qualifiers
  ////////////////////////////////////////////////////////////////////////////

  // Single stepping or debug mode means no debug activity may be assumed
  assign no_debug = !(rvfi_dcsr_i[rvfi_chk_pkg::DCSR_STEP_BIT] || debug_mode_i);

  // mcause may be rewritten by an NMI between two retirements
  assign mcause_qual = no_debug && !pending_nmi_i;

  // The NMI address must match its value of the previous cycle
  assign nmi_qual = no_debug && (nmi_addr_i == nmi_addr_q);

  // Last cycle's NMI address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_addr_q <= '0;
    end else begin
      nmi_addr_q <= nmi_addr_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Armed rule state
  ////////////////////////////////////////////////////////////////////////////

  // A valid retirement re-arms every flag from its own trap word and dcsr.
  // Between retirements a flag whose qualifier breaks is dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_q      <= '0;
      trap_intr_q <= 1'b0;
      trap_dbg_q  <= 1'b0;
      mcause_q    <= 1'b0;
      step_q      <= 1'b0;
      nmi_q       <= 1'b0;
    end else if (rvfi_valid_i) begin
      trap_q      <= rvfi_trap_i;
      trap_intr_q <= rvfi_trap_i[rvfi_chk_pkg::TRAP_BIT] && no_debug;
      trap_dbg_q  <= rvfi_trap_i[rvfi_chk_pkg::DBG_BIT];
      mcause_q    <= rvfi_trap_i[rvfi_chk_pkg::EXC_BIT] && mcause_qual;
      // Exception taken while single stepping
      step_q      <= rvfi_trap_i[rvfi_chk_pkg::EXC_BIT] &&
                     rvfi_trap_i[rvfi_chk_pkg::DBG_BIT];
      nmi_q       <= rvfi_dcsr_i[rvfi_chk_pkg::DCSR_NMIP_BIT] && nmi_qual;
    end else begin
      trap_intr_q <= trap_intr_q && no_debug;
      mcause_q    <= mcause_q && mcause_qual;
      nmi_q       <= nmi_q && nmi_qual;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding debug acknowledges
  ////////////////////////////////////////////////////////////////////////////

  assign dbg_ret = rvfi_valid_i && (rvfi_dbg_i != '0);

  // Ack and debug retirement in the same cycle cancel each other out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_cnt_q <= 2'd0;
    end else if (dbg_ack_i && !dbg_ret && (ack_cnt_q != 2'd3)) begin
      ack_cnt_q <= ack_cnt_q + 2'd1;
    end else if (dbg_ret && !dbg_ack_i && (ack_cnt_q != 2'd0)) begin
      ack_cnt_q <= ack_cnt_q - 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Interface outputs
  ////////////////////////////////////////////////////////////////////////////

  assign trace_o.ret_valid        = rvfi_valid_i;
  assign trace_o.ret_trap         = rvfi_trap_i;
  assign trace_o.ret_intr         = rvfi_intr_i;
  assign trace_o.ret_dbg          = rvfi_dbg_i;
  assign trace_o.ret_mcause_cause = rvfi_mcause_i[7:0];
  assign trace_o.ret_dcsr_cause   = rvfi_dcsr_i[rvfi_chk_pkg::DCSR_CAUSE_LSB +: 3];
  assign trace_o.ret_pc           = rvfi_pc_i;

  assign trace_o.prev_exc_cause = trap_q[rvfi_chk_pkg::EXC_CAUSE_LSB +: 6];
  assign trace_o.prev_dbg_cause = trap_q[rvfi_chk_pkg::DBG_CAUSE_LSB +: 3];

  // The qualifiers must still hold on the checked retirement itself
  assign trace_o.armed_trap_intr = trap_intr_q && no_debug;
  assign trace_o.armed_trap_dbg  = trap_dbg_q;
  assign trace_o.armed_mcause    = mcause_q && mcause_qual;
  assign trace_o.armed_step_ok   = step_q;
  assign trace_o.armed_nmi       = nmi_q && nmi_qual;

  // NMI handler entry is word aligned
  assign trace_o.nmi_pc          = {nmi_addr_i[31:2], 2'b00};
  assign trace_o.dbg_ack_pending = (ack_cnt_q != 2'd0);

endmodule

// File: src/rvfi_trace_if.sv
////////////////////////////////////////////////////////////////////////////
// Decoded retirement and armed-rule state carried from the trace
// decoder to the rule check
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface rvfi_trace_if;

  // Current retirement passed through from the core
  logic                    ret_valid;
  rvfi_chk_pkg::trap_t     ret_trap;
  logic                    ret_intr;
  rvfi_chk_pkg::dbg_cause_t ret_dbg;
  logic [7:0]              ret_mcause_cause;
  rvfi_chk_pkg::dbg_cause_t ret_dcsr_cause;
  rvfi_chk_pkg::word_t     ret_pc;

  // Cause fields of the previous valid retirement
  rvfi_chk_pkg::exc_cause_t prev_exc_cause;
  rvfi_chk_pkg::dbg_cause_t prev_dbg_cause;

  // Rules armed by the previous retirement with the qualifiers already applied
  logic armed_trap_intr;
  logic armed_trap_dbg;
  logic armed_mcause;
  logic armed_step_ok;
  logic armed_nmi;

  // Expected NMI handler address and debug acknowledge bookkeeping
  rvfi_chk_pkg::word_t nmi_pc;
  logic                dbg_ack_pending;

  modport decode_mp (
    output ret_valid, ret_trap, ret_intr, ret_dbg, ret_mcause_cause,
    output ret_dcsr_cause, ret_pc, prev_exc_cause, prev_dbg_cause,
    output armed_trap_intr, armed_trap_dbg, armed_mcause, armed_step_ok,
    output armed_nmi, nmi_pc, dbg_ack_pending
  );

  modport check_mp (
    input ret_valid, ret_trap, ret_intr, ret_dbg, ret_mcause_cause,
    input ret_dcsr_cause, ret_pc, prev_exc_cause, prev_dbg_cause,
    input armed_trap_intr, armed_trap_dbg, armed_mcause, armed_step_ok,
    input armed_nmi, nmi_pc, dbg_ack_pending
  );

endinterface

// File: src/rvfi_chk_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Vector types, trap word and dcsr field positions, debug and NMI cause
// codes, rule indices and the rule count of the retirement trace checker
////////////////////////////////////////////////////////////////////////////

package rvfi_chk_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Rule indices and vector types
  ////////////////////////////////////////////////////////////////////////////

  // Number of consistency rules with one violation bit and one count each
  localparam int unsigned NUM_RULES = 7;

  localparam int unsigned R_TRAP_INTR       = 0;
  localparam int unsigned R_TRAP_DBG        = 1;
  localparam int unsigned R_MCAUSE_ALIGN    = 2;
  localparam int unsigned R_DBG_CAUSE_ALIGN = 3;
  localparam int unsigned R_STEP_TRAP       = 4;
  localparam int unsigned R_DBG_ACK         = 5;
  localparam int unsigned R_NMI_HANDLER     = 6;

  // Data word as seen on mcause, dcsr, PC and the NMI address
  typedef logic [31:0] word_t;

  // Trap word of one retirement
  typedef logic [13:0] trap_t;

  typedef logic [5:0] exc_cause_t;
  typedef logic [2:0] dbg_cause_t;

  // One bit per rule
  typedef logic [NUM_RULES-1:0] rule_vec_t;

  // Saturating violation count of a single rule
  typedef logic [7:0] viol_cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // Field positions
  ////////////////////////////////////////////////////////////////////////////

  // Trap word layout with bits 13:12 left unchecked
  localparam int unsigned TRAP_BIT      = 0;
  localparam int unsigned EXC_BIT       = 1;
  localparam int unsigned DBG_BIT       = 2;
  localparam int unsigned EXC_CAUSE_LSB = 3;
  localparam int unsigned DBG_CAUSE_LSB = 9;

  // dcsr layout
  localparam int unsigned DCSR_STEP_BIT  = 2;
  localparam int unsigned DCSR_NMIP_BIT  = 3;
  localparam int unsigned DCSR_CAUSE_LSB = 6;

  ////////////////////////////////////////////////////////////////////////////
  // Cause codes
  ////////////////////////////////////////////////////////////////////////////

  // Debug cause reported for single stepping
  localparam dbg_cause_t DBG_CAUSE_STEP = 3'd4;

  // The two NMI causes in mcause[7:0] with the interrupt bit folded into bit 7
  localparam logic [7:0] INT_CAUSE_LOAD_FAULT  = 8'h80;
  localparam logic [7:0] INT_CAUSE_STORE_FAULT = 8'h81;

endpackage
